// ==== project.f ====
src/cache_pkg.sv
src/cache_ifs.sv
src/tag_cam.sv
src/line_store.sv
src/block_xfer.sv
src/cache_ctrl.sv
src/cache_top.sv
tb/tb_cache_top.sv

// ==== src/block_xfer.sv ====
module block_xfer #(
	parameter int  ADDR_W         = cache_pkg::ADDR_W,
	parameter int  WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE,
	localparam int OFF_W          = $clog2(WORDS_PER_LINE),
	localparam int TAG_W          = ADDR_W - OFF_W
)(
	input  logic              clock_i,
	input  logic              resetn_i,
	xfer_if.xfer              xfer,

	input  logic              buffer_read_ready_i,
	input  logic              buffer_write_ready_i,
	input  logic              mem_ready_i,
	output logic              buffer_read_ack_o,
	output logic              buffer_write_ack_o,

	// memory command
	output logic              mem_req_o,
	output logic              mem_req_block_o,
	output logic              mem_rw_o,           // 1 = block write
	output logic [ADDR_W-1:0] mem_addr_o
);

	logic [OFF_W-1:0] word_q;
	logic             fill_busy_q;    // fill started, words still to come
	logic             fill_req_q;     // fill request not yet taken
	logic             wb_busy_q;      // words still to send
	logic             wb_pending_q;   // write block request not yet taken
	logic [TAG_W-1:0] wb_addr_q;

	logic rd_ack;
	logic wr_ack;
	logic fill_go;
	logic wb_go;

	// writeback words drain before fill words are taken
	assign rd_ack  = fill_busy_q && !wb_busy_q && buffer_read_ready_i;
	assign wr_ack  = wb_busy_q && buffer_write_ready_i;

	// an outstanding write request goes before the next fill
	assign wb_go   = wb_pending_q && mem_ready_i;
	assign fill_go = fill_req_q && !wb_pending_q && mem_ready_i;

	assign buffer_read_ack_o  = rd_ack;
	assign buffer_write_ack_o = wr_ack;

	assign mem_req_o       = fill_go | wb_go;
	assign mem_req_block_o = mem_req_o;           // always whole blocks
	assign mem_rw_o        = wb_go;
	assign mem_addr_o      = {wb_go ? wb_addr_q : xfer.block_addr, {OFF_W{1'b0}}};

	assign xfer.word_idx   = word_q;
	assign xfer.last_word  = (word_q == OFF_W'(WORDS_PER_LINE - 1));
	assign xfer.fill_busy  = fill_busy_q;
	assign xfer.wb_pending = wb_pending_q;

	// victim tag is overwritten by the fill, so keep a copy
	always_ff @(posedge clock_i) begin
		if (xfer.wb_start)
			wb_addr_q <= xfer.wb_addr;
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			word_q       <= '0;
			fill_busy_q  <= 1'b0;
			fill_req_q   <= 1'b0;
			wb_busy_q    <= 1'b0;
			wb_pending_q <= 1'b0;
		end else begin
			if (rd_ack || wr_ack)
				word_q <= xfer.last_word ? '0 : word_q + 1'b1;

			if (xfer.fill_start) begin
				fill_busy_q <= 1'b1;
				fill_req_q  <= 1'b1;
			end else begin
				if (fill_go)
					fill_req_q <= 1'b0;
				if (rd_ack && xfer.last_word)
					fill_busy_q <= 1'b0;
			end

			if (xfer.wb_start)
				wb_busy_q <= 1'b1;
			else if (wr_ack && xfer.last_word)
				wb_busy_q <= 1'b0;

			// request may go once the first word sits in the buffer
			if (wr_ack && word_q == '0)
				wb_pending_q <= 1'b1;
			else if (wb_go)
				wb_pending_q <= 1'b0;
		end
	end

	a_req_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |-> mem_ready_i);

endmodule

// ==== src/cache_ctrl.sv ====
module cache_ctrl #(
	parameter int  ADDR_W         = cache_pkg::ADDR_W,
	parameter int  LINE_COUNT     = cache_pkg::LINE_COUNT,
	parameter int  WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE,
	localparam int IDX_W          = $clog2(LINE_COUNT),
	localparam int OFF_W          = $clog2(WORDS_PER_LINE),
	localparam int TAG_W          = ADDR_W - OFF_W
)(
	input  logic                          clock_i,
	input  logic                          resetn_i,

	// core
	input  logic                          core_req_i,
	input  logic                          core_rw_i,      // 1 = write
	input  logic [ADDR_W-1:0]             core_addr_i,
	input  logic [cache_pkg::DATA_W-1:0]  core_data_i,
	output logic                          core_done_o,
	output logic                          core_hit_o,
	output logic [cache_pkg::DATA_W-1:0]  core_data_o,

	// performance pulses
	output logic                          flag_hit_o,
	output logic                          flag_miss_o,
	output logic                          flag_writeback_o,

	// buffer status, acks come from block_xfer
	input  logic                          buffer_read_ready_i,
	input  logic                          buffer_write_ready_i,
	input  logic [cache_pkg::DATA_W-1:0]  buffer_data_i,

	cam_if.ctrl                           cam,
	xfer_if.ctrl                          xfer,

	// line data memory
	output logic [IDX_W+OFF_W-1:0]        ls_addr_o,
	output logic                          ls_we_o,
	output logic [cache_pkg::DATA_W-1:0]  ls_wdata_o,
	input  logic [cache_pkg::DATA_W-1:0]  ls_rdata_i
);

	cache_pkg::state_e state_q;

	logic [IDX_W-1:0]             rp_q;         // round-robin victim
	logic                         req_q;        // miss in flight, replay pending
	logic                         rw_q;         // op of the missed request
	logic [cache_pkg::DATA_W-1:0] core_data_q;  // read word held between dones

	logic [TAG_W-1:0] core_tag;
	logic [OFF_W-1:0] core_word;
	logic             req_active;
	logic             rw_now;
	logic [OFF_W-1:0] next_word;

	assign core_tag   = core_addr_i[ADDR_W-1:OFF_W];
	assign core_word  = core_addr_i[OFF_W-1:0];
	assign req_active = core_req_i | req_q;
	assign rw_now     = req_q ? rw_q : core_rw_i;

	// no request pending reads as a hit so the core never sees a stall
	assign core_hit_o  = req_active ? cam.hit : 1'b1;
	assign core_data_o = core_done_o ? ls_rdata_i : core_data_q;

	// ----------------------------------------
	// tag store and transfer control
	// ----------------------------------------
	assign cam.lookup_tag  = core_tag;
	assign cam.victim_line = rp_q;
	assign cam.wr_line     = rp_q;
	assign cam.wr_en       = (state_q == cache_pkg::ST_READ_BUFFER) &&
	                         buffer_read_ready_i && xfer.last_word;
	assign cam.dirty_set   = (state_q == cache_pkg::ST_NORMAL) && req_active &&
	                         cam.hit && rw_now;
	assign cam.dirty_clr   = (state_q == cache_pkg::ST_WRITE_BUFFER) &&
	                         buffer_write_ready_i && xfer.last_word;

	assign xfer.fill_start = (state_q == cache_pkg::ST_WAIT_READY) && !xfer.wb_pending;
	assign xfer.wb_start   = (state_q == cache_pkg::ST_WAIT_VICTIM) && cam.victim_dirty;
	assign xfer.block_addr = core_tag;         // core holds its address until done
	assign xfer.wb_addr    = cam.victim_tag;

	// sync read memory, so writeback presents the word one cycle ahead
	always_comb begin
		if (!buffer_write_ready_i)
			next_word = xfer.word_idx;
		else if (xfer.last_word)
			next_word = '0;
		else
			next_word = xfer.word_idx + 1'b1;
	end

	always_comb begin
		ls_addr_o  = {cam.hit_line, core_word};
		ls_we_o    = 1'b0;
		ls_wdata_o = core_data_i;
		case (state_q)
			cache_pkg::ST_NORMAL: begin
				ls_we_o = req_active && cam.hit && rw_now;
			end
			cache_pkg::ST_WAIT_VICTIM: begin
				ls_addr_o = {rp_q, {OFF_W{1'b0}}};   // prefetch word 0
			end
			cache_pkg::ST_WRITE_BUFFER: begin
				ls_addr_o = {rp_q, next_word};
			end
			cache_pkg::ST_READ_BUFFER: begin
				ls_addr_o  = {rp_q, xfer.word_idx};
				ls_we_o    = buffer_read_ready_i;
				ls_wdata_o = buffer_data_i;
			end
			default: begin
				ls_we_o = 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q          <= cache_pkg::ST_NORMAL;
			rp_q             <= IDX_W'(LINE_COUNT - 1);   // first miss rolls to line 0
			req_q            <= 1'b0;
			rw_q             <= 1'b0;
			core_done_o      <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
		end else begin
			core_done_o      <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;

			case (state_q)
				cache_pkg::ST_NORMAL: begin
					if (req_active) begin
						if (cam.hit) begin                // new hit or replay
							core_done_o <= 1'b1;
							flag_hit_o  <= 1'b1;
							req_q       <= 1'b0;
						end else begin
							flag_miss_o <= 1'b1;
							req_q       <= 1'b1;
							rw_q        <= core_rw_i;
							rp_q        <= (rp_q == IDX_W'(LINE_COUNT - 1)) ? '0 : rp_q + 1'b1;
							state_q     <= cache_pkg::ST_WAIT_READY;
						end
					end
				end

				cache_pkg::ST_WAIT_READY: begin
					if (!xfer.wb_pending)
						state_q <= cache_pkg::ST_WAIT_VICTIM;
				end

				cache_pkg::ST_WAIT_VICTIM: begin
					if (cam.victim_dirty) begin
						flag_writeback_o <= 1'b1;
						state_q          <= cache_pkg::ST_WRITE_BUFFER;
					end else begin
						state_q <= cache_pkg::ST_READ_BUFFER;
					end
				end

				cache_pkg::ST_WRITE_BUFFER: begin
					if (buffer_write_ready_i && xfer.last_word)
						state_q <= cache_pkg::ST_READ_BUFFER;
				end

				cache_pkg::ST_READ_BUFFER: begin
					if (buffer_read_ready_i && xfer.last_word)
						state_q <= cache_pkg::ST_NORMAL;   // replay as a hit
				end

				default: state_q <= cache_pkg::ST_NORMAL;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (core_done_o)
			core_data_q <= ls_rdata_i;
	end

	// a line under eviction or fill must never answer the lookup
	a_hit_not_victim: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(state_q != cache_pkg::ST_NORMAL && cam.hit) |-> (cam.hit_line != rp_q));

	a_fill_start_idle: assert property (@(posedge clock_i) disable iff (!resetn_i)
		xfer.fill_start |-> !xfer.fill_busy);

endmodule

// ==== src/cache_ifs.sv ====
// controller <-> tag store
interface cam_if #(
	parameter int ADDR_W         = cache_pkg::ADDR_W,
	parameter int LINE_COUNT     = cache_pkg::LINE_COUNT,
	parameter int WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE
);
	localparam int IDX_W = $clog2(LINE_COUNT);
	localparam int TAG_W = ADDR_W - $clog2(WORDS_PER_LINE);

	logic [TAG_W-1:0] lookup_tag;   // block address of the request
	logic             wr_en;        // install lookup_tag at wr_line
	logic [IDX_W-1:0] wr_line;
	logic             dirty_set;    // marks hit_line
	logic             dirty_clr;    // clears victim_line
	logic [IDX_W-1:0] victim_line;

	logic             hit;
	logic [IDX_W-1:0] hit_line;
	logic             victim_dirty;
	logic [TAG_W-1:0] victim_tag;

	modport ctrl (
		output lookup_tag, wr_en, wr_line, dirty_set, dirty_clr, victim_line,
		input  hit, hit_line, victim_dirty, victim_tag
	);

	modport cam (
		input  lookup_tag, wr_en, wr_line, dirty_set, dirty_clr, victim_line,
		output hit, hit_line, victim_dirty, victim_tag
	);
endinterface

// controller <-> block transfer sequencer
interface xfer_if #(
	parameter int ADDR_W         = cache_pkg::ADDR_W,
	parameter int WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE
);
	localparam int OFF_W = $clog2(WORDS_PER_LINE);
	localparam int TAG_W = ADDR_W - OFF_W;

	logic             fill_start;   // one cycle pulse
	logic             wb_start;     // one cycle pulse
	logic [TAG_W-1:0] block_addr;   // block to fetch
	logic [TAG_W-1:0] wb_addr;      // block being evicted

	logic [OFF_W-1:0] word_idx;
	logic             last_word;
	logic             fill_busy;
	logic             wb_pending;   // write block request not yet issued

	modport ctrl (
		output fill_start, wb_start, block_addr, wb_addr,
		input  word_idx, last_word, fill_busy, wb_pending
	);

	modport xfer (
		input  fill_start, wb_start, block_addr, wb_addr,
		output word_idx, last_word, fill_busy, wb_pending
	);
endinterface

// ==== src/cache_pkg.sv ====
package cache_pkg;

	// ----------------------------------------
	// default geometry
	// ----------------------------------------
	parameter int ADDR_W         = 16;     // word address width
	parameter int LINE_COUNT     = 8;      // lines in the cache
	parameter int WORDS_PER_LINE = 4;      // words per block

	parameter int DATA_W         = 32;     // one data word

	// ----------------------------------------
	// controller states
	// ----------------------------------------
	typedef enum logic [2:0] {
		ST_NORMAL       = 3'b000,      // lookup
		ST_WAIT_READY   = 3'b001,      // hold fill until old writeback req is out
		ST_WAIT_VICTIM  = 3'b010,      // victim line known, check dirty
		ST_WRITE_BUFFER = 3'b011,      // dirty words out to write buffer
		ST_READ_BUFFER  = 3'b100       // fill words in from read buffer
	} state_e;

endpackage

// ==== src/cache_top.sv ====
module cache_top #(
	parameter int  ADDR_W         = cache_pkg::ADDR_W,
	parameter int  LINE_COUNT     = cache_pkg::LINE_COUNT,
	parameter int  WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE,
	localparam int LS_AW          = $clog2(LINE_COUNT) + $clog2(WORDS_PER_LINE)
)(
	input  logic                         clock_i,
	input  logic                         resetn_i,

	// core
	input  logic                         core_req_i,
	input  logic                         core_rw_i,
	input  logic [ADDR_W-1:0]            core_addr_i,
	input  logic [cache_pkg::DATA_W-1:0] core_data_i,
	output logic                         core_done_o,
	output logic                         core_hit_o,
	output logic [cache_pkg::DATA_W-1:0] core_data_o,

	// read buffer, mem -> cache
	input  logic                         buffer_read_ready_i,
	input  logic [cache_pkg::DATA_W-1:0] buffer_data_i,
	output logic                         buffer_read_ack_o,

	// write buffer, cache -> mem
	input  logic                         buffer_write_ready_i,
	output logic                         buffer_write_ack_o,
	output logic [cache_pkg::DATA_W-1:0] buffer_data_o,

	// memory command
	input  logic                         mem_ready_i,
	output logic                         mem_req_o,
	output logic                         mem_req_block_o,
	output logic                         mem_rw_o,
	output logic [ADDR_W-1:0]            mem_addr_o,

	// performance
	output logic                         flag_hit_o,
	output logic                         flag_miss_o,
	output logic                         flag_writeback_o
);

	logic [LS_AW-1:0]             ls_addr;
	logic                         ls_we;
	logic [cache_pkg::DATA_W-1:0] ls_wdata;
	logic [cache_pkg::DATA_W-1:0] ls_rdata;

	cam_if #(
		.ADDR_W         (ADDR_W),
		.LINE_COUNT     (LINE_COUNT),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) cam_bus ();

	xfer_if #(
		.ADDR_W         (ADDR_W),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) xfer_bus ();

	assign buffer_data_o = ls_rdata;   // writeback words straight from line memory

	// ----------------------------------------
	// instances
	// ----------------------------------------
	cache_ctrl #(
		.ADDR_W         (ADDR_W),
		.LINE_COUNT     (LINE_COUNT),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_ctrl (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.core_req_i           (core_req_i),
		.core_rw_i            (core_rw_i),
		.core_addr_i          (core_addr_i),
		.core_data_i          (core_data_i),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.core_data_o          (core_data_o),
		.flag_hit_o           (flag_hit_o),
		.flag_miss_o          (flag_miss_o),
		.flag_writeback_o     (flag_writeback_o),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_write_ready_i (buffer_write_ready_i),
		.buffer_data_i        (buffer_data_i),
		.cam                  (cam_bus.ctrl),
		.xfer                 (xfer_bus.ctrl),
		.ls_addr_o            (ls_addr),
		.ls_we_o              (ls_we),
		.ls_wdata_o           (ls_wdata),
		.ls_rdata_i           (ls_rdata)
	);

	tag_cam #(
		.ADDR_W         (ADDR_W),
		.LINE_COUNT     (LINE_COUNT),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_cam (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.cam      (cam_bus.cam)
	);

	line_store #(
		.LINE_COUNT     (LINE_COUNT),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_lines (
		.clock_i (clock_i),
		.addr_i  (ls_addr),
		.we_i    (ls_we),
		.wdata_i (ls_wdata),
		.rdata_o (ls_rdata)
	);

	block_xfer #(
		.ADDR_W         (ADDR_W),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_xfer (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.xfer                 (xfer_bus.xfer),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_write_ready_i (buffer_write_ready_i),
		.mem_ready_i          (mem_ready_i),
		.buffer_read_ack_o    (buffer_read_ack_o),
		.buffer_write_ack_o   (buffer_write_ack_o),
		.mem_req_o            (mem_req_o),
		.mem_req_block_o      (mem_req_block_o),
		.mem_rw_o             (mem_rw_o),
		.mem_addr_o           (mem_addr_o)
	);

endmodule

// ==== src/line_store.sv ====
module line_store #(
	parameter int  LINE_COUNT     = cache_pkg::LINE_COUNT,
	parameter int  WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE,
	localparam int AW             = $clog2(LINE_COUNT) + $clog2(WORDS_PER_LINE)
)(
	input  logic                         clock_i,
	input  logic [AW-1:0]                addr_i,    // {line, word}
	input  logic                         we_i,
	input  logic [cache_pkg::DATA_W-1:0] wdata_i,
	output logic [cache_pkg::DATA_W-1:0] rdata_o
);

	logic [cache_pkg::DATA_W-1:0] mem [LINE_COUNT * WORDS_PER_LINE];

	// read-first, data one cycle after the address
	always_ff @(posedge clock_i) begin
		rdata_o <= mem[addr_i];
		if (we_i)
			mem[addr_i] <= wdata_i;
	end

endmodule

// ==== src/tag_cam.sv ====
module tag_cam #(
	parameter int  ADDR_W         = cache_pkg::ADDR_W,
	parameter int  LINE_COUNT     = cache_pkg::LINE_COUNT,
	parameter int  WORDS_PER_LINE = cache_pkg::WORDS_PER_LINE,
	localparam int IDX_W          = $clog2(LINE_COUNT),
	localparam int TAG_W          = ADDR_W - $clog2(WORDS_PER_LINE)
)(
	input  logic clock_i,
	input  logic resetn_i,
	cam_if.cam   cam
);

	logic [TAG_W-1:0]      tag_q [LINE_COUNT];
	logic [LINE_COUNT-1:0] valid_q;
	logic [LINE_COUNT-1:0] dirty_q;
	logic [LINE_COUNT-1:0] match;

	// ----------------------------------------
	// associative lookup
	// ----------------------------------------
	always_comb begin
		cam.hit_line = '0;
		for (int i = 0; i < LINE_COUNT; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == cam.lookup_tag);
			if (match[i])
				cam.hit_line = IDX_W'(i);
		end
	end

	assign cam.hit          = |match;
	assign cam.victim_tag   = tag_q[cam.victim_line];
	assign cam.victim_dirty = dirty_q[cam.victim_line];   // invalid lines stay clean

	// tag payload
	always_ff @(posedge clock_i) begin
		if (cam.wr_en)
			tag_q[cam.wr_line] <= cam.lookup_tag;
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (cam.wr_en) begin
				valid_q[cam.wr_line] <= 1'b1;
				dirty_q[cam.wr_line] <= 1'b0;   // fresh block from memory
			end
			if (cam.dirty_set)
				dirty_q[cam.hit_line] <= 1'b1;
			if (cam.dirty_clr)
				dirty_q[cam.victim_line] <= 1'b0;
		end
	end

	a_one_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match));

endmodule

// ==== tb/tb_cache_top.sv ====
module tb_cache_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W         = 16;
	localparam int LINES          = 4;         // few lines so evictions come quickly
	localparam int WPL            = 4;
	localparam int DW             = cache_pkg::DATA_W;
	localparam int OFF_W          = $clog2(WPL);
	localparam int TAG_W          = ADDR_W - OFF_W;
	localparam int N_TXN          = 300;
	localparam int N_BLOCKS       = 12;
	localparam int TIMEOUT_CYCLES = N_TXN * 40 + 200;

	logic              clock_i = 1'b0;
	logic              resetn_i;
	logic              core_req_i, core_rw_i;
	logic [ADDR_W-1:0] core_addr_i;
	logic [DW-1:0]     core_data_i;
	logic              core_done_o, core_hit_o;
	logic [DW-1:0]     core_data_o;
	logic              buffer_read_ready_i, buffer_read_ack_o;
	logic [DW-1:0]     buffer_data_i;
	logic              buffer_write_ready_i, buffer_write_ack_o;
	logic [DW-1:0]     buffer_data_o;
	logic              mem_ready_i, mem_req_o, mem_req_block_o, mem_rw_o;
	logic [ADDR_W-1:0] mem_addr_o;
	logic              flag_hit_o, flag_miss_o, flag_writeback_o;

	// memory side model
	logic [DW-1:0]     mem_arr [2**ADDR_W];
	logic [DW-1:0]     rdq[$];            // read buffer with its front on buffer_data_i
	logic [DW-1:0]     wrq[$];            // write buffer
	logic [ADDR_W-1:0] pend_wr[$];        // block writes waiting for their words

	// reference cache model
	logic [DW-1:0]     gold [logic [ADDR_W-1:0]];   // last written value per address
	logic [TAG_W-1:0]  tag_m [LINES];
	logic [LINES-1:0]  valid_m;
	logic [LINES-1:0]  dirty_m;
	int                rp_m;
	logic [ADDR_W-1:0] exp_wb_addr[$];
	logic [DW-1:0]     exp_wb_words[$];
	logic [TAG_W-1:0]  fill_blk;          // block of the request in flight
	logic              started;

	int          errors;
	int          checks;
	int unsigned cycle_cnt = 0;

	cache_top #(
		.ADDR_W         (ADDR_W),
		.LINE_COUNT     (LINES),
		.WORDS_PER_LINE (WPL)
	) UUT (.*);

	always #5 clock_i = ~clock_i;

	always @(posedge clock_i)
		cycle_cnt <= cycle_cnt + 1;

	// ----------------------------------------
	// checks and model helpers
	// ----------------------------------------
	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic ensure(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR t=%0t %s", $time, what);
		end
	endtask

	function automatic logic [DW-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return {~a, a ^ 16'h6a5c};   // every address bit matters
	endfunction

	function automatic logic [DW-1:0] gold_word(input logic [ADDR_W-1:0] a);
		return gold.exists(a) ? gold[a] : fill_word(a);
	endfunction

	function automatic logic [TAG_W-1:0] pool_block(input int k);
		return TAG_W'(k * 613 + 40);   // spread blocks over the address space
	endfunction

	// ready strobes and read data 1 ns after the edge
	task automatic drive_buffers();
		forever begin
			@(posedge clock_i);
			#1;
			buffer_data_i        = (rdq.size() != 0) ? rdq[0] : '0;
			buffer_read_ready_i  = (rdq.size() != 0) && ($urandom_range(3) != 0);
			buffer_write_ready_i = ($urandom_range(3) != 0);
			mem_ready_i          = ($urandom_range(2) != 0);
		end
	endtask

	// sampled at the falling edge where DUT outputs have settled
	task automatic memory_side();
		logic [ADDR_W-1:0] a;
		logic [DW-1:0]     w;
		if (buffer_read_ack_o) begin
			ensure(rdq.size() != 0, "read buffer ack with the read buffer empty");
			if (rdq.size() != 0)
				w = rdq.pop_front();
		end
		if (buffer_write_ack_o)
			wrq.push_back(buffer_data_o);
		if (mem_req_o) begin
			expect_eq("mem_req_block_o", mem_req_block_o, 1'b1);
			if (mem_rw_o) begin
				ensure(exp_wb_addr.size() != 0, "block write request with no dirty eviction");
				if (exp_wb_addr.size() != 0) begin
					a = exp_wb_addr.pop_front();
					expect_eq("mem_addr_o", mem_addr_o, a);
				end
				pend_wr.push_back(mem_addr_o);
			end else begin
				expect_eq("mem_addr_o", mem_addr_o, {fill_blk, OFF_W'(0)});
				for (int k = 0; k < WPL; k++)
					rdq.push_back(mem_arr[ADDR_W'(mem_addr_o + k)]);
			end
		end
		// block write lands once all its words sit in the buffer
		if (pend_wr.size() != 0 && wrq.size() >= WPL) begin
			a = pend_wr.pop_front();
			for (int k = 0; k < WPL; k++) begin
				w = wrq.pop_front();
				mem_arr[ADDR_W'(a + k)] = w;
				ensure(exp_wb_words.size() != 0, "writeback word with no expected line data");
				if (exp_wb_words.size() != 0)
					expect_eq("buffer_data_o", w, exp_wb_words.pop_front());
			end
		end
	endtask

	always @(negedge clock_i) begin
		if (resetn_i) begin
			if (!started)
				ensure(!(core_done_o | mem_req_o | mem_req_block_o | mem_rw_o |
				         buffer_read_ack_o | buffer_write_ack_o |
				         flag_hit_o | flag_miss_o | flag_writeback_o),
				       "output active after reset before any request");
			if (mem_req_o)
				ensure(mem_ready_i, "memory request issued while mem_ready_i is low");
			memory_side();
		end
	end

	// ----------------------------------------
	// one core transaction against the model
	// ----------------------------------------
	task automatic access(
		input logic              rw,
		input logic [ADDR_W-1:0] addr,
		input logic [DW-1:0]     data
	);
		logic [TAG_W-1:0] blk;
		logic             hit;
		logic             wb;
		int               line;
		int               wb_seen;
		logic [DW-1:0]    exp_rd;
		blk     = addr[ADDR_W-1:OFF_W];
		hit     = 1'b0;
		wb      = 1'b0;
		line    = 0;
		wb_seen = 0;
		for (int i = 0; i < LINES; i++) begin
			if (valid_m[i] && tag_m[i] == blk) begin
				hit  = 1'b1;
				line = i;
			end
		end
		if (!hit) begin
			rp_m = (rp_m == LINES - 1) ? 0 : rp_m + 1;   // round robin victim
			line = rp_m;
			wb   = valid_m[line] && dirty_m[line];
			if (wb) begin
				exp_wb_addr.push_back({tag_m[line], OFF_W'(0)});
				for (int k = 0; k < WPL; k++)
					exp_wb_words.push_back(gold_word({tag_m[line], OFF_W'(k)}));
			end
			tag_m[line]   = blk;
			valid_m[line] = 1'b1;
			dirty_m[line] = 1'b0;
		end
		exp_rd = gold_word(addr);
		if (rw) begin
			gold[addr]    = data;
			dirty_m[line] = 1'b1;
		end

		@(posedge clock_i);
		#1;
		core_req_i  = 1'b1;
		core_rw_i   = rw;
		core_addr_i = addr;
		core_data_i = data;
		fill_blk    = blk;
		started     = 1'b1;
		@(negedge clock_i);
		expect_eq("core_hit_o", core_hit_o, hit);
		@(posedge clock_i);
		#1;
		core_req_i = 1'b0;
		@(negedge clock_i);
		expect_eq("core_done_o", core_done_o, hit);      // hit answers in one cycle
		expect_eq("flag_hit_o", flag_hit_o, hit);
		expect_eq("flag_miss_o", flag_miss_o, !hit);
		while (!core_done_o) begin
			@(negedge clock_i);
			if (flag_writeback_o)
				wb_seen++;
			ensure(!flag_miss_o, "second miss pulse within one request");
		end
		if (!hit)
			expect_eq("flag_hit_o", flag_hit_o, 1'b1);   // replay after fill
		expect_eq("flag_writeback_o", wb_seen, wb);
		if (!rw)
			expect_eq("core_data_o", core_data_o, exp_rd);
		repeat ($urandom_range(2)) begin
			@(negedge clock_i);
			ensure(!(core_done_o | flag_hit_o | flag_miss_o | flag_writeback_o),
			       "done or flag pulse while no request is pending");
			if (!rw)
				expect_eq("core_data_o", core_data_o, exp_rd);   // read word holds
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'h6ff3_d9e7));
		resetn_i             = 1'b0;
		core_req_i           = 1'b0;
		core_rw_i            = 1'b0;
		core_addr_i          = '0;
		core_data_i          = '0;
		buffer_read_ready_i  = 1'b0;
		buffer_data_i        = '0;
		buffer_write_ready_i = 1'b0;
		mem_ready_i          = 1'b0;
		started              = 1'b0;
		fill_blk             = '0;
		errors               = 0;
		checks               = 0;
		rp_m                 = LINES - 1;   // first miss lands on line 0
		valid_m              = '0;
		dirty_m              = '0;
		for (int a = 0; a < 2**ADDR_W; a++)
			mem_arr[a] = fill_word(ADDR_W'(a));

		repeat (4) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;
		fork
			drive_buffers();
		join_none
		repeat (3) @(posedge clock_i);   // quiet window after reset

		for (int n = 0; n < N_TXN; n++)
			access(1'($urandom_range(1)),
			       {pool_block($urandom_range(N_BLOCKS - 1)), OFF_W'($urandom_range(WPL - 1))},
			       $urandom);

		// let the last block write reach memory
		while (exp_wb_addr.size() != 0 || pend_wr.size() != 0)
			@(negedge clock_i);
		ensure(rdq.size() == 0 && wrq.size() == 0, "words left over in the buffers at the end");

		$display("errors=%0d checks=%0d", errors, checks);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, a request never completed", TIMEOUT_CYCLES);
		$display("errors=%0d checks=%0d", errors, checks);
		$display("TEST FAIL");
		$finish;
	end

endmodule
